/* Bender.yml */
package:
  name: qdr_subsys

sources:
  - include_dirs:
      - common
    files:
      - common/qdr_pkg.sv
      - qdr_ctrl/qdr_cmd_sched.sv
      - qdr_ctrl/qdr_wr_path.sv
      - qdr_ctrl/qdr_rd_capture.sv
      - logic/qdr_sram_dev.sv
      - logic/qdr_subsys_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - bench/qdr_checker.sv
      - bench/qdr_subsys_tb.sv

/* bench/qdr_checker.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_config.svh"

module qdr_checker (
    input  wire logic                        k,
    input  wire logic                        rst_n,
    input  wire logic                        wr_req,
    input  wire logic [`QDR_ADDR_BITS-1:0]   wr_addr,
    input  wire qdr_pkg::qdr_beat_u          wr_data0,
    input  wire qdr_pkg::qdr_beat_u          wr_data1,
    input  wire qdr_pkg::qdr_be_t            wr_be0,
    input  wire qdr_pkg::qdr_be_t            wr_be1,
    input  wire logic                        rd_req,
    input  wire logic [`QDR_ADDR_BITS-1:0]   rd_addr,
    input  wire logic                        wr_busy,
    input  wire logic                        rd_busy,
    input  wire logic                        rd_valid,
    input  wire qdr_pkg::qdr_beat_u          rd_data0,
    input  wire qdr_pkg::qdr_beat_u          rd_data1,
    input  wire logic [8*16-1:0]             test_name,
    input  wire logic [2*`QDR_DATA_BITS-1:0] test_exp,
    input  wire logic                        test_exp_given,
    output int                               n_pass,
    output int                               n_fail,
    output int                               n_open
);

    import qdr_pkg::*;

    // a read normally returns within a handful of cycles
    localparam int rd_timeout = 30;

    // shadow of the two beat banks, updated in bus-issue order
    qdr_beat_u                   shadow0 [qdr_bank_depth];
    qdr_beat_u                   shadow1 [qdr_bank_depth];

    // outstanding reads, oldest first, since the DUT returns them in issue order
    logic [2*`QDR_DATA_BITS-1:0] exp_q  [$];
    logic [8*16-1:0]             name_q [$];
    int                          born_q [$];

    // mirrors the scheduler's record of who won the last conflict
    bit                          last_wr;
    int                          cyc;

    // strobes seen at the previous edge, whose busy level must be up by now
    bit                          wr_seen;
    bit                          rd_seen;

    task automatic merge_write;
        for (int i = 0; i < `QDR_BYTE_LANES; i++)
        begin
            if (wr_be0[i])
                shadow0[wr_addr].lanes[i] = wr_data0.lanes[i];
            if (wr_be1[i])
                shadow1[wr_addr].lanes[i] = wr_data1.lanes[i];
        end
    endtask

    // directed entries bring their own expected burst, random ones use the shadow
    task automatic queue_read;
        if (test_exp_given)
            exp_q.push_back(test_exp);
        else
            exp_q.push_back({shadow0[rd_addr].word, shadow1[rd_addr].word});
        name_q.push_back(test_name);
        born_q.push_back(cyc);
    endtask

    task automatic take_return;
        logic [2*`QDR_DATA_BITS-1:0] exp;
        logic [2*`QDR_DATA_BITS-1:0] got;
        logic [8*16-1:0]             name;
        int                          born;
        got = {rd_data0.word, rd_data1.word};
        if (exp_q.size() == 0)
        begin
            $display("rd_valid pulsed with no read outstanding, data %h", got);
            n_fail++;
        end
        else
        begin
            exp  = exp_q.pop_front();
            name = name_q.pop_front();
            born = born_q.pop_front();
            if (got !== exp)
            begin
                $display("CHECK FAILED %0s expected %h actual %h", name, exp, got);
                n_fail++;
            end
            else
            begin
                $display("ok %0s returned %h after %0d cycles", name, got, cyc - born);
                n_pass++;
            end
        end
    endtask

    task automatic drop_stale;
        logic [8*16-1:0]             name;
        int                          born;
        if (born_q.size() != 0 && cyc - born_q[0] > rd_timeout)
        begin
            exp_q.delete(0);
            name = name_q.pop_front();
            born = born_q.pop_front();
            $display("read of %0s strobed at cycle %0d got no rd_valid within %0d cycles",
                     name, born, rd_timeout);
            n_fail++;
        end
    endtask

    always @(posedge k or negedge rst_n)
    begin
        if (!rst_n)
        begin
            last_wr = 1'b1;
            cyc     = 0;
            n_pass  = 0;
            n_fail  = 0;
            n_open  = 0;
            wr_seen = 1'b0;
            rd_seen = 1'b0;
            exp_q.delete();
            name_q.delete();
            born_q.delete();
        end
        else
        begin
            cyc++;
            if (rd_valid)
                take_return();
            drop_stale();
            // a request is held at least one cycle before it issues, so busy shows it
            if (wr_seen && !wr_busy)
            begin
                $display("wr_busy stayed low in the cycle after a write was strobed");
                n_fail++;
            end
            if (rd_seen && !rd_busy)
            begin
                $display("rd_busy stayed low in the cycle after a read was strobed");
                n_fail++;
            end
            wr_seen = wr_req;
            rd_seen = rd_req;
            // a same-cycle pair goes out by alternation, read first after reset
            if (wr_req && rd_req)
            begin
                if (last_wr)
                begin
                    queue_read();
                    merge_write();
                end
                else
                begin
                    merge_write();
                    queue_read();
                end
                last_wr = !last_wr;
            end
            else if (wr_req)
                merge_write();
            else if (rd_req)
                queue_read();
            n_open = exp_q.size();
        end
    end

endmodule

`default_nettype wire

/* bench/qdr_subsys_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_config.svh"

module qdr_subsys_tb;

    import qdr_pkg::*;

    localparam int max_tests   = 32;
    localparam int busy_limit  = 50;
    localparam int drain_limit = 100;

    // what a table entry strobes
    localparam logic [1:0] op_wr   = 2'd0;
    localparam logic [1:0] op_rd   = 2'd1;
    localparam logic [1:0] op_both = 2'd2;

    logic                        k;
    logic                        rst_n;
    logic                        wr_req;
    logic                        rd_req;
    logic [`QDR_ADDR_BITS-1:0]   wr_addr;
    logic [`QDR_ADDR_BITS-1:0]   rd_addr;
    qdr_beat_u                   wr_data0;
    qdr_beat_u                   wr_data1;
    qdr_be_t                     wr_be0;
    qdr_be_t                     wr_be1;
    wire logic                   wr_busy;
    wire logic                   rd_busy;
    wire logic                   rd_valid;
    wire qdr_beat_u              rd_data0;
    wire qdr_beat_u              rd_data1;

    // the entry being strobed, so the checker can name it and knows what it expects
    logic [8*16-1:0]             cur_name;
    logic [2*`QDR_DATA_BITS-1:0] cur_exp;
    logic                        cur_exp_given;
    int                          n_pass;
    int                          n_fail;
    int                          n_open;

    // stimulus table, expected read bursts are {beat 0, beat 1}
    logic [8*16-1:0]             t_name [max_tests];
    logic [1:0]                  t_op   [max_tests];
    logic [`QDR_ADDR_BITS-1:0]   t_addr [max_tests];
    logic [`QDR_DATA_BITS-1:0]   t_d0   [max_tests];
    logic [`QDR_DATA_BITS-1:0]   t_d1   [max_tests];
    qdr_be_t                     t_be0  [max_tests];
    qdr_be_t                     t_be1  [max_tests];
    logic [2*`QDR_DATA_BITS-1:0] t_exp  [max_tests];
    // random entries draw their data when applied and the checker predicts them
    bit                          t_rnd  [max_tests];
    int                          n_tests;
    int                          n_reads;
    int                          seed;
    int                          idx;
    bit                          aborted;
    bit                          ready;

    qdr_subsys_top dut_i (
        .k        (k),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .wr_addr  (wr_addr),
        .wr_data0 (wr_data0),
        .wr_data1 (wr_data1),
        .wr_be0   (wr_be0),
        .wr_be1   (wr_be1),
        .rd_req   (rd_req),
        .rd_addr  (rd_addr),
        .wr_busy  (wr_busy),
        .rd_busy  (rd_busy),
        .rd_valid (rd_valid),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    qdr_checker chk_i (
        .k              (k),
        .rst_n          (rst_n),
        .wr_req         (wr_req),
        .wr_addr        (wr_addr),
        .wr_data0       (wr_data0),
        .wr_data1       (wr_data1),
        .wr_be0         (wr_be0),
        .wr_be1         (wr_be1),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .wr_busy        (wr_busy),
        .rd_busy        (rd_busy),
        .rd_valid       (rd_valid),
        .rd_data0       (rd_data0),
        .rd_data1       (rd_data1),
        .test_name      (cur_name),
        .test_exp       (cur_exp),
        .test_exp_given (cur_exp_given),
        .n_pass         (n_pass),
        .n_fail         (n_fail),
        .n_open         (n_open)
    );

    initial
    begin
        k = 1'b0;
        forever
            #4 k = ~k;
    end

    task automatic add_entry(
        input logic [8*16-1:0]             name,
        input logic [1:0]                  op,
        input logic [`QDR_ADDR_BITS-1:0]   addr,
        input logic [`QDR_DATA_BITS-1:0]   d0,
        input logic [`QDR_DATA_BITS-1:0]   d1,
        input qdr_be_t                     be0,
        input qdr_be_t                     be1,
        input logic [2*`QDR_DATA_BITS-1:0] exp,
        input bit                          rnd
    );
        t_name[n_tests] = name;
        t_op[n_tests]   = op;
        t_addr[n_tests] = addr;
        t_d0[n_tests]   = d0;
        t_d1[n_tests]   = d1;
        t_be0[n_tests]  = be0;
        t_be1[n_tests]  = be1;
        t_exp[n_tests]  = exp;
        t_rnd[n_tests]  = rnd;
        if (op != op_wr)
            n_reads++;
        n_tests++;
    endtask

    task automatic build_table;
        logic [`QDR_ADDR_BITS-1:0] addr;
        logic [7:0]                digit;
        int                        i;
        // full burst, then partial writes where each beat enables a different byte
        add_entry("full_wr_a5", op_wr, 6'd5, 16'h1234, 16'habcd, 2'b11, 2'b11, 32'h0, 1'b0);
        add_entry("full_rd_a5", op_rd, 6'd5, 16'h0, 16'h0, 2'b00, 2'b00, 32'h1234_abcd, 1'b0);
        add_entry("part_wr_a5", op_wr, 6'd5, 16'h5566, 16'h7788, 2'b01, 2'b10, 32'h0, 1'b0);
        add_entry("part_rd_a5", op_rd, 6'd5, 16'h0, 16'h0, 2'b00, 2'b00, 32'h1266_77cd, 1'b0);
        add_entry("part2_wr_a5", op_wr, 6'd5, 16'h9900, 16'h00ee, 2'b10, 2'b01, 32'h0, 1'b0);
        add_entry("part2_rd_a5", op_rd, 6'd5, 16'h0, 16'h0, 2'b00, 2'b00, 32'h9966_77ee, 1'b0);
        // the first same-cycle pair after reset serves the read, the next one the write
        add_entry("init_wr_a9", op_wr, 6'd9, 16'h1111, 16'h2222, 2'b11, 2'b11, 32'h0, 1'b0);
        add_entry("pair1_a9", op_both, 6'd9, 16'h3333, 16'h4444, 2'b11, 2'b11, 32'h1111_2222, 1'b0);
        add_entry("pair2_a9", op_both, 6'd9, 16'h5555, 16'h6666, 2'b11, 2'b11, 32'h5555_6666, 1'b0);
        add_entry("after_rd_a9", op_rd, 6'd9, 16'h0, 16'h0, 2'b00, 2'b00, 32'h5555_6666, 1'b0);
        // reads strobed as soon as rd_busy allows, so several are in flight
        add_entry("full_wr_a63", op_wr, 6'd63, 16'hcafe, 16'hf00d, 2'b11, 2'b11, 32'h0, 1'b0);
        add_entry("b2b_rd_a5", op_rd, 6'd5, 16'h0, 16'h0, 2'b00, 2'b00, 32'h9966_77ee, 1'b0);
        add_entry("b2b_rd_a63", op_rd, 6'd63, 16'h0, 16'h0, 2'b00, 2'b00, 32'hcafe_f00d, 1'b0);
        add_entry("b2b_rd_a9", op_rd, 6'd9, 16'h0, 16'h0, 2'b00, 2'b00, 32'h5555_6666, 1'b0);
        // random bursts spread over the whole address range
        addr  = '0;
        digit = "0";
        for (i = 0; i < 8; i++)
        begin
            add_entry({64'h0, "rnd_wr_", digit}, op_wr, addr, 16'h0, 16'h0, 2'b11, 2'b11,
                      32'h0, 1'b1);
            addr  = addr + 6'd9;
            digit = digit + 8'd1;
        end
        // then every one of them is read back once all the writes are out
        addr  = '0;
        digit = "0";
        for (i = 0; i < 8; i++)
        begin
            add_entry({64'h0, "rnd_rd_", digit}, op_rd, addr, 16'h0, 16'h0, 2'b00, 2'b00,
                      32'h0, 1'b1);
            addr  = addr + 6'd9;
            digit = digit + 8'd1;
        end
    endtask

    // waits at falling edges until the entry's busy levels are low
    task automatic wait_idle(input int n, output bit ok);
        int  waited;
        bit  need_wr;
        bit  need_rd;
        waited  = 0;
        ok      = 1'b1;
        need_wr = (t_op[n] != op_rd);
        need_rd = (t_op[n] != op_wr);
        while (ok && ((need_wr && wr_busy) || (need_rd && rd_busy)))
        begin
            if (waited == busy_limit)
            begin
                $display("busy stayed high for %0d cycles before %0s", busy_limit, t_name[n]);
                ok = 1'b0;
            end
            else
            begin
                @(negedge k);
                waited++;
            end
        end
    endtask

    // strobes one entry for a single cycle, starting at a falling edge
    task automatic apply_entry(input int n);
        logic [31:0] rnd_word;
        wr_data0.word = t_d0[n];
        wr_data1.word = t_d1[n];
        if (t_rnd[n])
        begin
            rnd_word      = $urandom;
            wr_data0.word = rnd_word[`QDR_DATA_BITS-1:0];
            rnd_word      = $urandom;
            wr_data1.word = rnd_word[`QDR_DATA_BITS-1:0];
        end
        wr_be0        = t_be0[n];
        wr_be1        = t_be1[n];
        wr_addr       = t_addr[n];
        rd_addr       = t_addr[n];
        cur_name      = t_name[n];
        cur_exp       = t_exp[n];
        cur_exp_given = !t_rnd[n];
        wr_req        = (t_op[n] != op_rd);
        rd_req        = (t_op[n] != op_wr);
        @(negedge k);
        wr_req = 1'b0;
        rd_req = 1'b0;
    endtask

    initial
    begin
        int waited;
        seed          = 95;
        seed          = $urandom(seed);
        rst_n         = 1'b0;
        wr_req        = 1'b0;
        rd_req        = 1'b0;
        wr_addr       = '0;
        rd_addr       = '0;
        wr_data0      = '0;
        wr_data1      = '0;
        wr_be0        = '0;
        wr_be1        = '0;
        cur_name      = '0;
        cur_exp       = '0;
        cur_exp_given = 1'b0;
        n_tests       = 0;
        n_reads       = 0;
        aborted       = 1'b0;
        idx           = 0;
        build_table();
        repeat (8) @(posedge k);
        @(negedge k);
        rst_n = 1'b1;
        @(negedge k);
        while (!aborted && idx < n_tests)
        begin
            wait_idle(idx, ready);
            if (ready)
                apply_entry(idx);
            else
                aborted = 1'b1;
            idx++;
        end
        // let the reads still in flight come back
        waited = 0;
        while (n_open != 0 && waited < drain_limit)
        begin
            @(negedge k);
            waited++;
        end
        if (n_open != 0)
        begin
            $display("%0d reads still outstanding after %0d cycles", n_open, drain_limit);
            aborted = 1'b1;
        end
        $display("reads passed %0d, failed %0d, of %0d in the table", n_pass, n_fail, n_reads);
        if (!aborted && n_fail == 0 && n_pass == n_reads)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* common/qdr_config.svh */
`ifndef QDR_CONFIG_SVH
`define QDR_CONFIG_SVH

// burst address width, so each bank holds 64 bursts
`define QDR_ADDR_BITS 6

// width of one data beat on d and q
`define QDR_DATA_BITS 16

// number of byte lanes per beat, each with its own bw_n bit
`define QDR_BYTE_LANES 2

// rising edges from the device sampling r_n low to beat 0 on q
// the design also runs with 1 or 3 here
`define QDR_RD_LATENCY 2

`endif

/* common/qdr_pkg.sv */
`default_nettype none

`include "qdr_config.svh"

package qdr_pkg;

    // width of one byte lane, the masking granule of bw_n
    localparam int unsigned qdr_lane_bits = 8;

    // number of bursts held in each beat bank of the device
    localparam int unsigned qdr_bank_depth = 1 << `QDR_ADDR_BITS;

    // one data beat as seen on d and q
    // the word view carries the beat around the subsystem, while the lane view
    // is what masked merges use, one byte at a time
    typedef union packed {
        logic [`QDR_DATA_BITS-1:0]                       word;
        logic [`QDR_BYTE_LANES-1:0][qdr_lane_bits-1:0]   lanes;
    } qdr_beat_u;

    // per-beat byte enable, active high on the user side
    // the write path inverts it to form the active-low bw_n pins
    typedef logic [`QDR_BYTE_LANES-1:0] qdr_be_t;

endpackage

`default_nettype wire

/* logic/qdr_sram_dev.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_config.svh"

module qdr_sram_dev (
    input  wire logic                      k,
    input  wire logic                      rst_n,
    input  wire logic [`QDR_ADDR_BITS-1:0] sa,
    input  wire logic                      w_n,
    input  wire logic                      r_n,
    input  wire qdr_pkg::qdr_beat_u        d,
    input  wire qdr_pkg::qdr_be_t          bw_n,
    output qdr_pkg::qdr_beat_u             q
);

    import qdr_pkg::*;

    // bank 0 holds the first beat of every burst, bank 1 the second
    qdr_beat_u                 bank0 [qdr_bank_depth];
    qdr_beat_u                 bank1 [qdr_bank_depth];

    // write marker and address for beat 1, one edge behind the command
    logic                      wr_m1;
    logic [`QDR_ADDR_BITS-1:0] wa1;

    // read markers and addresses for the two bank lookups of a burst
    logic                      rd_m0;
    logic                      rd_m1;
    logic [`QDR_ADDR_BITS-1:0] ra0;
    logic [`QDR_ADDR_BITS-1:0] ra1;

    // beat pipeline towards q, the last stage is the pin itself
    qdr_beat_u                 q_pipe [`QDR_RD_LATENCY];

    always_ff @(posedge k or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_m1 <= 1'b0;
            rd_m0 <= 1'b0;
            rd_m1 <= 1'b0;
        end
        else
        begin
            wr_m1 <= ~w_n;
            rd_m0 <= ~r_n;
            rd_m1 <= rd_m0;
        end
    end

    always_ff @(posedge k)
    begin
        wa1 <= sa;
        ra0 <= sa;
        ra1 <= ra0;
    end

    // masked merge, lane by lane, so a disabled byte keeps its stored value
    // beat 0 lands at the edge that samples w_n low, beat 1 on the next edge
    always_ff @(posedge k)
    begin
        for (int i = 0; i < `QDR_BYTE_LANES; i++)
        begin
            if (!w_n && !bw_n[i])
                bank0[sa].lanes[i] <= d.lanes[i];
            if (wr_m1 && !bw_n[i])
                bank1[wa1].lanes[i] <= d.lanes[i];
        end
    end

    // bank 0 is looked up one edge after r_n low and bank 1 one edge later,
    // each on the same edge where a write issued right after the read
    // would merge that bank, so the read still returns the old data
    // and a write issued just before it is already visible
    always_ff @(posedge k or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int j = 0; j < `QDR_RD_LATENCY; j++)
                q_pipe[j] <= '0;
        end
        else
        begin
            if (rd_m0)
                q_pipe[0] <= bank0[ra0];
            else if (rd_m1)
                q_pipe[0] <= bank1[ra1];
            else
                q_pipe[0] <= '0;
            for (int j = 1; j < `QDR_RD_LATENCY; j++)
                q_pipe[j] <= q_pipe[j-1];
        end
    end

    // zero on q whenever no read beat is due
    assign q = q_pipe[`QDR_RD_LATENCY-1];

    // beat 1 of a write uses the edge after w_n low, so a second write
    // there would fight it for d and bw_n
    a_wr_spacing: assert property (@(posedge k) disable iff (!rst_n) !w_n |=> w_n);

endmodule

`default_nettype wire

/* logic/qdr_subsys_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_config.svh"

module qdr_subsys_top (
    input  wire logic                      k,
    input  wire logic                      rst_n,
    input  wire logic                      wr_req,
    input  wire logic [`QDR_ADDR_BITS-1:0] wr_addr,
    input  wire qdr_pkg::qdr_beat_u        wr_data0,
    input  wire qdr_pkg::qdr_beat_u        wr_data1,
    input  wire qdr_pkg::qdr_be_t          wr_be0,
    input  wire qdr_pkg::qdr_be_t          wr_be1,
    input  wire logic                      rd_req,
    input  wire logic [`QDR_ADDR_BITS-1:0] rd_addr,
    output wire logic                      wr_busy,
    output wire logic                      rd_busy,
    output wire logic                      rd_valid,
    output wire qdr_pkg::qdr_beat_u        rd_data0,
    output wire qdr_pkg::qdr_beat_u        rd_data1
);

    import qdr_pkg::*;

    // the QDR bus between controller and device
    wire logic [`QDR_ADDR_BITS-1:0] sa;
    wire logic                      w_n;
    wire logic                      r_n;
    wire qdr_beat_u                 d;
    wire qdr_beat_u                 q;
    wire qdr_be_t                   bw_n;

    // tells the write path that its latched burst owns the bus this cycle
    wire logic                      wr_issue;

    qdr_cmd_sched sched_i (
        .k        (k),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .rd_req   (rd_req),
        .wr_addr  (wr_addr),
        .rd_addr  (rd_addr),
        .sa       (sa),
        .w_n      (w_n),
        .r_n      (r_n),
        .wr_issue (wr_issue),
        .wr_busy  (wr_busy),
        .rd_busy  (rd_busy)
    );

    qdr_wr_path wr_path_i (
        .k        (k),
        .rst_n    (rst_n),
        .wr_req   (wr_req),
        .wr_issue (wr_issue),
        .wr_data0 (wr_data0),
        .wr_data1 (wr_data1),
        .wr_be0   (wr_be0),
        .wr_be1   (wr_be1),
        .d        (d),
        .bw_n     (bw_n)
    );

    qdr_rd_capture rd_capture_i (
        .k        (k),
        .rst_n    (rst_n),
        .r_n      (r_n),
        .q        (q),
        .rd_valid (rd_valid),
        .rd_data0 (rd_data0),
        .rd_data1 (rd_data1)
    );

    qdr_sram_dev sram_i (
        .k     (k),
        .rst_n (rst_n),
        .sa    (sa),
        .w_n   (w_n),
        .r_n   (r_n),
        .d     (d),
        .bw_n  (bw_n),
        .q     (q)
    );

endmodule

`default_nettype wire

/* qdr_ctrl/qdr_cmd_sched.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_config.svh"

module qdr_cmd_sched (
    input  wire logic                      k,
    input  wire logic                      rst_n,
    input  wire logic                      wr_req,
    input  wire logic                      rd_req,
    input  wire logic [`QDR_ADDR_BITS-1:0] wr_addr,
    input  wire logic [`QDR_ADDR_BITS-1:0] rd_addr,
    output logic      [`QDR_ADDR_BITS-1:0] sa,
    output logic                           w_n,
    output logic                           r_n,
    output logic                           wr_issue,
    output logic                           wr_busy,
    output logic                           rd_busy
);

    // one pending slot per request type
    logic                      wr_pend;
    logic                      rd_pend;
    logic [`QDR_ADDR_BITS-1:0] wr_addr_q;
    logic [`QDR_ADDR_BITS-1:0] rd_addr_q;

    // set for one cycle after a command of that type, while its data bus is busy
    logic                      wr_cool;
    logic                      rd_cool;

    // remembers which side won the last read/write conflict
    logic                      last_wr;

    logic                      wr_elig;
    logic                      rd_elig;
    logic                      pick_wr;
    logic                      pick_rd;

    assign wr_elig = wr_pend & ~wr_cool;
    assign rd_elig = rd_pend & ~rd_cool;

    // on a conflict the read goes first if the write won the previous one
    // and after reset last_wr starts high so the first conflict serves the read
    assign pick_rd = rd_elig & (~wr_elig | last_wr);
    assign pick_wr = wr_elig & ~pick_rd;

    // the write path registers beat 0 at the same edge that drives w_n low
    assign wr_issue = pick_wr;
    assign wr_busy  = wr_pend;
    assign rd_busy  = rd_pend;

    always_ff @(posedge k or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_pend <= 1'b0;
            rd_pend <= 1'b0;
            wr_cool <= 1'b0;
            rd_cool <= 1'b0;
            last_wr <= 1'b1;
            w_n     <= 1'b1;
            r_n     <= 1'b1;
        end
        else
        begin
            wr_pend <= wr_req | (wr_pend & ~pick_wr);
            rd_pend <= rd_req | (rd_pend & ~pick_rd);
            wr_cool <= pick_wr;
            rd_cool <= pick_rd;
            // only a real conflict flips the priority
            if (wr_elig && rd_elig)
                last_wr <= pick_wr;
            w_n     <= ~pick_wr;
            r_n     <= ~pick_rd;
        end
    end

    always_ff @(posedge k)
    begin
        if (wr_req)
            wr_addr_q <= wr_addr;
        if (rd_req)
            rd_addr_q <= rd_addr;
        if (pick_wr)
            sa <= wr_addr_q;
        else if (pick_rd)
            sa <= rd_addr_q;
    end

    // the shared bus carries one command per cycle
    a_one_cmd: assert property (@(posedge k) disable iff (!rst_n) w_n || r_n);

    // the user side must honour busy, the pending slots are only one deep
    a_wr_busy: assert property (@(posedge k) disable iff (!rst_n) wr_req |-> !wr_busy);
    a_rd_busy: assert property (@(posedge k) disable iff (!rst_n) rd_req |-> !rd_busy);

endmodule

`default_nettype wire

/* qdr_ctrl/qdr_rd_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "qdr_config.svh"

module qdr_rd_capture (
    input  wire logic               k,
    input  wire logic               rst_n,
    input  wire logic               r_n,
    input  wire qdr_pkg::qdr_beat_u q,
    output logic                    rd_valid,
    output qdr_pkg::qdr_beat_u      rd_data0,
    output qdr_pkg::qdr_beat_u      rd_data1
);

    // stage j holds a read whose r_n low was sampled j edges ago
    localparam int mark_depth = `QDR_RD_LATENCY + 2;

    // one marker per issued read, so several reads can be in flight at once
    // and they come back in the order they went out
    logic [mark_depth-1:0] mark;

    always_ff @(posedge k or negedge rst_n)
    begin
        if (!rst_n)
        begin
            mark     <= '0;
            rd_valid <= 1'b0;
        end
        else
        begin
            // the device samples r_n at this same edge, so the two stay in step
            mark     <= {mark[mark_depth-2:0], ~r_n};
            rd_valid <= mark[mark_depth-1];
        end
    end

    // beat 0 sits on q while the marker is in the second last stage,
    // and beat 1 arrives one edge later together with the completion pulse
    always_ff @(posedge k)
    begin
        if (mark[mark_depth-2])
            rd_data0 <= q;
        if (mark[mark_depth-1])
            rd_data1 <= q;
    end

    // each burst holds q for two beats, so the scheduler must space reads apart
    // and adjacent markers would mean two bursts collide on q
    a_read_spacing: assert property (@(posedge k) disable iff (!rst_n)
        (mark[mark_depth-1:1] & mark[mark_depth-2:0]) == '0);

endmodule

`default_nettype wire

/* qdr_ctrl/qdr_wr_path.sv */
`timescale 1ns/1ps
`default_nettype none

module qdr_wr_path (
    input  wire logic               k,
    input  wire logic               rst_n,
    input  wire logic               wr_req,
    input  wire logic               wr_issue,
    input  wire qdr_pkg::qdr_beat_u wr_data0,
    input  wire qdr_pkg::qdr_beat_u wr_data1,
    input  wire qdr_pkg::qdr_be_t   wr_be0,
    input  wire qdr_pkg::qdr_be_t   wr_be1,
    output qdr_pkg::qdr_beat_u      d,
    output qdr_pkg::qdr_be_t        bw_n
);

    import qdr_pkg::*;

    // the burst waits here until the scheduler gets the bus for it,
    // which can be a cycle late when a read wins a conflict
    qdr_beat_u lat0;
    qdr_beat_u lat1;
    qdr_be_t   be_lat0;
    qdr_be_t   be_lat1;

    // high in the cycle after w_n was driven low, when beat 1 goes out
    logic      beat1_due;

    always_ff @(posedge k)
    begin
        if (wr_req)
        begin
            lat0    <= wr_data0;
            lat1    <= wr_data1;
            be_lat0 <= wr_be0;
            be_lat1 <= wr_be1;
        end
    end

    always_ff @(posedge k or negedge rst_n)
    begin
        if (!rst_n)
        begin
            beat1_due <= 1'b0;
            bw_n      <= '1;
        end
        else
        begin
            beat1_due <= wr_issue;
            // the pins are active low, so enabled bytes drive a zero
            if (wr_issue)
                bw_n <= ~be_lat0;
            else if (beat1_due)
                bw_n <= ~be_lat1;
            else
                bw_n <= '1;
        end
    end

    // beat 0 shares the cycle with w_n low and beat 1 follows it
    always_ff @(posedge k)
    begin
        if (wr_issue)
            d <= lat0;
        else if (beat1_due)
            d <= lat1;
        else
            d <= '0;
    end

endmodule

`default_nettype wire

/* qdr_subsys.f */
+incdir+common
common/qdr_pkg.sv
qdr_ctrl/qdr_cmd_sched.sv
qdr_ctrl/qdr_wr_path.sv
qdr_ctrl/qdr_rd_capture.sv
logic/qdr_sram_dev.sv
logic/qdr_subsys_top.sv
bench/qdr_checker.sv
bench/qdr_subsys_tb.sv
